// ==== logic/sms_consts.svh ====
`ifndef SMS_CONSTS_SVH
`define SMS_CONSTS_SVH

// ========================================
// Download index codes
// ========================================
`define IDX_SYSMODE 8'd4    // System E mode byte
`define IDX_DSW     8'd254  // DIP switch bytes
`define IDX_GG      5'd2    // Low index bits, Game Gear image
`define IDX_SMS     5'd1    // Low index bits, Master System image

// ========================================
// Cartridge image layout
// ========================================
`define CART_AW     22
`define HDR_SIZE    10'd512          // Copier header
`define ID_ADDR     25'h0007FFC      // First of four ID bytes
`define ID_END_ADDR 25'h0008000      // ID complete here
`define YSJ_ID      32'h1370014F     // Ys (Japan) needs VDP version 1

// ========================================
// Clock enable divider
// ========================================
`define CE_PERIOD   5'd30
`define CE_ST_VDP0  5'd4
`define CE_ST_CPU0  5'd9
`define CE_ST_VDP1  5'd14
`define CE_ST_PIX1  5'd19
`define CE_ST_CPU1  5'd24

`endif

// ==== logic/sms_pkg.sv ====
package sms_pkg;

	// One cheat record as assembled from the host
	// Each field is little endian in the download stream
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// System E board configuration byte
	// Bit 0 sits in encrypt, bit 7 is e2_use
	typedef struct packed {
		logic       e2_use;   // Bit 7
		logic       e1_use;   // Bit 6
		logic [1:0] e0_type;  // Bits 5:4
		logic       pedal;    // Bit 3
		logic       paddle;   // Bit 2
		logic [1:0] encrypt;  // Base and bank decryption
	} sysmode_t;

endpackage

// ==== logic/load_if.sv ====
`timescale 1ns/10ps

// Host download bus, one byte per write strobe
interface load_if;
	logic        ioctl_download;  // Held for the whole transfer
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;        // One cycle per byte
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;

	modport source (
		output ioctl_download,
		output ioctl_index,
		output ioctl_wr,
		output ioctl_addr,
		output ioctl_dout
	);

	modport sink (
		input ioctl_download,
		input ioctl_index,
		input ioctl_wr,
		input ioctl_addr,
		input ioctl_dout
	);
endinterface

// ==== logic/load_cfg_regs.sv ====
`timescale 1ns/10ps
`include "sms_consts.svh"

module load_cfg_regs (
	input  logic              clk_sys,
	input  logic              RESET,
	load_if.sink              ld,
	output logic              cart_load,
	output logic              code_load,
	output sms_pkg::sysmode_t sysmode,
	output logic [7:0]        dsw_f2,
	output logic [7:0]        dsw_f3,
	output logic [7:0]        dsw_e0,
	output logic              gg,
	output logic              systeme
);

	logic       code_index;
	logic       sys_wr;
	logic       dsw_wr;
	logic       cart_wr;
	logic [4:0] idx_lo;

	// ========================================
	// Index decode
	// ========================================
	assign code_index = &ld.ioctl_index;  // Cheats use index FF
	assign code_load  = ld.ioctl_download & code_index;
	assign cart_load  = ld.ioctl_download & ~code_index &
		(ld.ioctl_index != `IDX_SYSMODE) & (ld.ioctl_index != `IDX_DSW);

	assign idx_lo  = ld.ioctl_index[4:0];
	assign cart_wr = ld.ioctl_wr & cart_load;
	assign sys_wr  = ld.ioctl_wr & ld.ioctl_download & (ld.ioctl_index == `IDX_SYSMODE);
	assign dsw_wr  = ld.ioctl_wr & ld.ioctl_download & (ld.ioctl_index == `IDX_DSW);

	// Only the leading bytes of each file matter
	always_ff @(posedge clk_sys) begin
		if (sys_wr && ld.ioctl_addr == 25'd0)
			sysmode <= ld.ioctl_dout;
		if (dsw_wr) begin
			case (ld.ioctl_addr)
				25'd0:   dsw_f2 <= ld.ioctl_dout;
				25'd1:   dsw_f3 <= ld.ioctl_dout;
				25'd2:   dsw_e0 <= ld.ioctl_dout;
				default: ;                           // Extra DIP bytes ignored
			endcase
		end
	end

	// Cartridge kind
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg      <= 1'b0;
			systeme <= 1'b0;
		end else begin
			if (cart_wr) begin
				gg <= (idx_lo == `IDX_GG);
				if (idx_lo == `IDX_SMS || idx_lo == `IDX_GG)
					systeme <= 1'b0;
			end
			if (sys_wr)
				systeme <= 1'b1;  // Mode byte only comes with System E sets
		end
	end

endmodule

// ==== logic/cart_loader.sv ====
`timescale 1ns/10ps
`include "sms_consts.svh"

module cart_loader (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_load,
	load_if.sink                 ld,
	input  logic                 rom_ack,
	output logic                 rom_wr,
	output logic                 ioctl_wait,
	output logic [23:0]          romwr_a,
	output logic [`CART_AW-1:0]  cart_mask,
	output logic [`CART_AW-1:0]  cart_mask512,
	output logic                 cart_sz512,
	output logic                 ysj_quirk
);

	logic                load_d;
	logic                load_rise;
	logic                load_fall;
	logic                cart_wr;
	logic [`CART_AW-1:0] wa;
	logic [31:0]         cart_id;

	assign cart_wr   = ld.ioctl_wr & cart_load;
	assign load_rise = cart_load & ~load_d;
	assign load_fall = ~cart_load & load_d;
	assign wa        = ld.ioctl_addr[`CART_AW-1:0];

	// ========================================
	// ROM store handshake
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			load_d     <= 1'b0;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
			romwr_a    <= 24'd0;
		end else begin
			load_d <= cart_load;
			if (cart_wr) begin
				rom_wr     <= ~rom_wr;  // Request by toggle
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && rom_wr == rom_ack) begin
				ioctl_wait <= 1'b0;
				romwr_a    <= romwr_a + 24'd1;
			end
			// New image always starts at zero
			if (load_rise)
				romwr_a <= 24'd0;
		end
	end

	// ========================================
	// Image size masks
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			if (ld.ioctl_addr == 25'd0)
				cart_mask <= '0;
			else
				cart_mask <= cart_mask | wa;
			// Header bytes land as junk until address 512 clears it
			if (ld.ioctl_addr == 25'(`HDR_SIZE))
				cart_mask512 <= '0;
			else
				cart_mask512 <= cart_mask512 | (wa - `CART_AW'(`HDR_SIZE));
		end
		if (load_fall)
			cart_sz512 <= ld.ioctl_addr[9];  // Odd 512 count means header
	end

	// ========================================
	// Title quirk detection
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr && (ld.ioctl_addr >> 2) == (`ID_ADDR >> 2)) begin
			case (ld.ioctl_addr[1:0])
				2'd0: cart_id[31:24] <= ld.ioctl_dout;  // Big endian
				2'd1: cart_id[23:16] <= ld.ioctl_dout;
				2'd2: cart_id[15:8]  <= ld.ioctl_dout;
				2'd3: cart_id[7:0]   <= ld.ioctl_dout;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ysj_quirk <= 1'b0;
		end else if (load_rise) begin
			ysj_quirk <= 1'b0;
		end else if (cart_wr && ld.ioctl_addr == `ID_END_ADDR) begin
			if (cart_id == `YSJ_ID)
				ysj_quirk <= 1'b1;
		end
	end

endmodule

// ==== logic/cheat_assembler.sv ====
`timescale 1ns/10ps

module cheat_assembler (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 code_load,
	load_if.sink                 ld,
	output sms_pkg::cheat_code_t cheat_code,
	output logic                 cheat_strobe
);

	logic       code_wr;
	logic [3:0] sel;
	logic [4:0] lane;

	assign code_wr = ld.ioctl_wr & code_load;
	assign sel     = ld.ioctl_addr[3:0];
	assign lane    = {sel[1:0], 3'b000};  // Bit offset in the field

	// ========================================
	// Record assembly
	// ========================================
	// Four bytes per field, least significant first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (sel[3:2])
				2'd0: cheat_code.flags[lane +: 8]   <= ld.ioctl_dout;
				2'd1: cheat_code.addr[lane +: 8]    <= ld.ioctl_dout;
				2'd2: cheat_code.compare[lane +: 8] <= ld.ioctl_dout;
				2'd3: cheat_code.replace[lane +: 8] <= ld.ioctl_dout;
			endcase
		end
	end

	// Last byte of record hands the code over
	always_ff @(posedge clk_sys) begin
		if (RESET)
			cheat_strobe <= 1'b0;
		else
			cheat_strobe <= code_wr && (sel == 4'hF);
	end

endmodule

// ==== logic/clk_enables.sv ====
`timescale 1ns/10ps
`include "sms_consts.svh"

module clk_enables (
	input  logic clk_sys,
	input  logic RESET,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	logic [4:0] clkd;  // Divider state, 0 to CE_PERIOD-1

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clkd   <= 5'd0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			if (clkd == `CE_PERIOD - 5'd1)
				clkd <= 5'd0;
			else
				clkd <= clkd + 5'd1;

			ce_sp  <= clkd[0];  // Half rate
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			case (clkd)
				`CE_ST_VDP0, `CE_ST_VDP1: ce_vdp <= 1'b1;
				`CE_ST_CPU0: begin
					ce_cpu <= 1'b1;
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				`CE_ST_PIX1, `CE_PERIOD - 5'd1: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				`CE_ST_CPU1: begin
					ce_cpu <= 1'b1;  // CPU phase matches HCounter tests
					ce_vdp <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== logic/sms_loader_top.sv ====
`timescale 1ns/10ps
`include "sms_consts.svh"

module sms_loader_top (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                ioctl_download,
	input  logic [7:0]          ioctl_index,
	input  logic                ioctl_wr,
	input  logic [24:0]         ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                rom_ack,
	output logic                ioctl_wait,
	output logic                rom_wr,
	output logic [23:0]         romwr_a,
	output logic [`CART_AW-1:0] cart_mask,
	output logic [`CART_AW-1:0] cart_mask512,
	output logic                cart_sz512,
	output logic                gg,
	output logic                systeme,
	output logic                ysj_quirk,
	output logic [7:0]          sysmode,
	output logic [7:0]          dsw_f2,
	output logic [7:0]          dsw_f3,
	output logic [7:0]          dsw_e0,
	output logic [31:0]         cheat_flags,
	output logic [31:0]         cheat_addr,
	output logic [31:0]         cheat_compare,
	output logic [31:0]         cheat_replace,
	output logic                cheat_strobe,
	output logic                ce_cpu,
	output logic                ce_vdp,
	output logic                ce_pix,
	output logic                ce_sp
);

	logic                 cart_load;
	logic                 code_load;
	sms_pkg::sysmode_t    sysmode_s;
	sms_pkg::cheat_code_t cheat_code;

	load_if ld ();

	assign ld.ioctl_download = ioctl_download;
	assign ld.ioctl_index    = ioctl_index;
	assign ld.ioctl_wr       = ioctl_wr;
	assign ld.ioctl_addr     = ioctl_addr;
	assign ld.ioctl_dout     = ioctl_dout;

	assign sysmode       = sysmode_s;
	assign cheat_flags   = cheat_code.flags;
	assign cheat_addr    = cheat_code.addr;
	assign cheat_compare = cheat_code.compare;
	assign cheat_replace = cheat_code.replace;

	load_cfg_regs u_cfg (
		.clk_sys(clk_sys), .RESET(RESET), .ld(ld.sink),
		.cart_load(cart_load), .code_load(code_load), .sysmode(sysmode_s),
		.dsw_f2(dsw_f2), .dsw_f3(dsw_f3), .dsw_e0(dsw_e0),
		.gg(gg), .systeme(systeme)
	);

	cart_loader u_cart (
		.clk_sys(clk_sys), .RESET(RESET), .cart_load(cart_load), .ld(ld.sink),
		.rom_ack(rom_ack), .rom_wr(rom_wr), .ioctl_wait(ioctl_wait), .romwr_a(romwr_a),
		.cart_mask(cart_mask), .cart_mask512(cart_mask512),
		.cart_sz512(cart_sz512), .ysj_quirk(ysj_quirk)
	);

	cheat_assembler u_cheat (
		.clk_sys(clk_sys), .RESET(RESET), .code_load(code_load), .ld(ld.sink),
		.cheat_code(cheat_code), .cheat_strobe(cheat_strobe)
	);

	clk_enables u_ce (
		.clk_sys(clk_sys), .RESET(RESET),
		.ce_cpu(ce_cpu), .ce_vdp(ce_vdp), .ce_pix(ce_pix), .ce_sp(ce_sp)
	);

endmodule

// ==== dv/sms_loader_chk.sv ====
`timescale 1ns/10ps

module sms_loader_chk (
	input logic        clk_sys,
	input logic        RESET,
	input logic        cart_wr,
	input logic        load_rise,
	input logic        rom_wr,
	input logic        rom_ack,
	input logic        ioctl_wait,
	input logic [23:0] romwr_a
);

	// ========================================
	// Handshake rules
	// ========================================
	// A request toggle follows a cartridge write
	property p_req_toggle;
		@(posedge clk_sys) disable iff (RESET)
		(rom_wr != $past(rom_wr)) |-> $past(cart_wr);
	endproperty

	// Wait ends only once the store matched the request
	property p_wait_release;
		@(posedge clk_sys) disable iff (RESET)
		$fell(ioctl_wait) |-> $past(rom_ack == rom_wr);
	endproperty

	property p_addr_step;
		@(posedge clk_sys) disable iff (RESET)
		(romwr_a != $past(romwr_a)) |-> ($fell(ioctl_wait) || $past(load_rise));
	endproperty

	a_req_toggle:   assert property (p_req_toggle)
		else $error("rom_wr toggled without a cartridge write");
	a_wait_release: assert property (p_wait_release)
		else $error("ioctl_wait fell before rom_ack matched rom_wr");
	a_addr_step:    assert property (p_addr_step)
		else $error("romwr_a moved outside a byte completion or load start");

endmodule

bind cart_loader sms_loader_chk chk (
	.clk_sys(clk_sys), .RESET(RESET), .cart_wr(cart_wr), .load_rise(load_rise),
	.rom_wr(rom_wr), .rom_ack(rom_ack), .ioctl_wait(ioctl_wait), .romwr_a(romwr_a)
);

// ==== dv/sms_loader_tb.sv ====
`timescale 1ns/10ps

module sms_loader_tb;

	logic        clk_sys = 1'b0;
	logic        RESET;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        rom_ack;
	logic        ioctl_wait, rom_wr, cart_sz512, gg, systeme, ysj_quirk, cheat_strobe;
	logic        ce_cpu, ce_vdp, ce_pix, ce_sp;
	logic [23:0] romwr_a;
	logic [21:0] cart_mask, cart_mask512;
	logic [7:0]  sysmode, dsw_f2, dsw_f3, dsw_e0;
	logic [31:0] cheat_flags, cheat_addr, cheat_compare, cheat_replace;

	logic [7:0]  host_bytes[$];  // Cartridge bytes not yet stored
	int          stored;         // Bytes stored in the current load
	int          strobes;
	int          cycles;
	int          limit = 200;    // Grows as stim lines are read
	int          ack_cnt;
	logic        ack_busy;

	always #5 clk_sys = ~clk_sys;

	sms_loader_top uut (.*);

	task automatic check_value(input string name, input logic [31:0] act,
		input logic [31:0] exp);
		if (act !== exp) begin
			$display("error %s: got %h expected %h", name, act, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// Fill data depends on every address bit
	function automatic logic [7:0] fill_byte(input logic [24:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]};
	endfunction

	function automatic logic is_cart(input logic [7:0] idx);
		return idx != 8'hFF && idx != 8'h04 && idx != 8'hFE;
	endfunction

	// ========================================
	// ROM store model
	// ========================================
	always @(negedge clk_sys) begin
		if (RESET) begin
			ack_busy = 1'b0;
		end else if (ack_busy) begin
			if (ack_cnt == 0) begin
				if (host_bytes.size() == 0) begin
					$display("store got a request with no byte sent by the host");
					$display("sim failed");
					$fatal(1);
				end
				check_value("romwr_a", 32'(romwr_a), stored);
				check_value("ioctl_dout", 32'(ioctl_dout), 32'(host_bytes.pop_front()));
				stored   = stored + 1;
				rom_ack  = rom_wr;
				ack_busy = 1'b0;
			end else begin
				ack_cnt = ack_cnt - 1;
			end
		end else if (rom_wr != rom_ack) begin
			ack_cnt  = $urandom % 6;  // 0 to 5 cycles of back-pressure
			ack_busy = 1'b1;
		end
	end

	always @(negedge clk_sys)
		if (!RESET && cheat_strobe)
			strobes = strobes + 1;

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: run took longer than %0d cycles", limit);
			$display("sim failed");
			$fatal(1);
		end
	end

	// ========================================
	// Host side tasks
	// ========================================
	task automatic host_start(input logic [7:0] idx);
		@(negedge clk_sys);
		ioctl_index    = idx;
		ioctl_download = 1'b1;
		stored         = 0;
		host_bytes.delete();
	endtask

	task automatic host_end();
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	task automatic host_write(input logic [24:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		ioctl_addr = a;
		ioctl_dout = d;
		ioctl_wr   = 1'b1;
		if (is_cart(ioctl_index))
			host_bytes.push_back(d);
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		while (ioctl_wait)  // Hold data until the store answers
			@(negedge clk_sys);
	endtask

	function automatic logic [31:0] read_output(input string name, output logic found);
		found = 1'b1;
		case (name)
			"romwr_a":       return 32'(romwr_a);
			"stored":        return stored;
			"cart_mask":     return 32'(cart_mask);
			"cart_mask512":  return 32'(cart_mask512);
			"cart_sz512":    return 32'(cart_sz512);
			"gg":            return 32'(gg);
			"systeme":       return 32'(systeme);
			"ysj_quirk":     return 32'(ysj_quirk);
			"sysmode":       return 32'(sysmode);
			"dsw_f2":        return 32'(dsw_f2);
			"dsw_f3":        return 32'(dsw_f3);
			"dsw_e0":        return 32'(dsw_e0);
			"cheat_flags":   return cheat_flags;
			"cheat_addr":    return cheat_addr;
			"cheat_compare": return cheat_compare;
			"cheat_replace": return cheat_replace;
			"strobes":       return strobes;
			default: begin
				found = 1'b0;
				return 32'd0;
			end
		endcase
	endfunction

	// Divider state s gives the enables seen one edge later
	task automatic check_enables(input int k);
		int s;
		s = (k - 1) % 30;
		check_value("ce_sp", 32'(ce_sp), 32'(s % 2 == 1));
		check_value("ce_vdp", 32'(ce_vdp), 32'(s % 5 == 4));
		check_value("ce_pix", 32'(ce_pix), 32'(s == 9 || s == 19 || s == 29));
		check_value("ce_cpu", 32'(ce_cpu), 32'(s == 9 || s == 24));
	endtask

	initial begin
		int          fd;
		int          n;
		int          cnt_sp, cnt_vdp, cnt_pix, cnt_cpu;
		string       line, cmd, name;
		logic [31:0] a, b, got;
		logic        found;

		RESET = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = 25'd0;
		ioctl_dout = 8'd0;
		rom_ack = 1'b0;
		stored = 0;
		strobes = 0;
		cycles = 0;
		cnt_sp = 0;
		cnt_vdp = 0;
		cnt_pix = 0;
		cnt_cpu = 0;
		void'($urandom(32'h1111));
		repeat (2) @(negedge clk_sys);
		RESET = 1'b0;

		// Clock enables over two divider periods
		for (int k = 1; k <= 60; k++) begin
			@(negedge clk_sys);
			check_enables(k);
			if (ce_cpu && cnt_cpu == 0)
				check_value("first ce_cpu cycle", k, 10);
			cnt_sp  += int'(ce_sp);
			cnt_vdp += int'(ce_vdp);
			cnt_pix += int'(ce_pix);
			cnt_cpu += int'(ce_cpu);
		end
		check_value("ce_sp count", cnt_sp, 30);
		check_value("ce_vdp count", cnt_vdp, 12);
		check_value("ce_pix count", cnt_pix, 6);
		check_value("ce_cpu count", cnt_cpu, 4);

		// System-mode load so a later Game Gear load has systeme to clear
		host_start(8'h04);
		host_write(25'd0, 8'h5A);
		host_end();
		@(negedge clk_sys);
		check_value("systeme", 32'(systeme), 32'd1);

		fd = $fopen("dv/sms_loader_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/sms_loader_stim.txt");
			$display("sim failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			cmd = "";
			if (n > 0)
				n = $sscanf(line, "%s", cmd);
			limit = limit + 20;
			case (cmd)
				"S": begin
					n = $sscanf(line, "%s %h", cmd, a);
					host_start(a[7:0]);
				end
				"W": begin
					n = $sscanf(line, "%s %h %h", cmd, a, b);
					host_write(a[24:0], b[7:0]);
				end
				"F": begin
					n = $sscanf(line, "%s %h %h", cmd, a, b);
					limit = limit + 12 * int'(b);
					for (int i = 0; i < int'(b); i++)
						host_write(a[24:0] + 25'(i), fill_byte(a[24:0] + 25'(i)));
				end
				"E": host_end();
				"C": begin
					n = $sscanf(line, "%s %h", cmd, a);
					limit = limit + int'(a);
					repeat (a) @(negedge clk_sys);
				end
				"X": begin
					n = $sscanf(line, "%s %s %h", cmd, name, b);
					got = read_output(name, found);
					if (!found) begin
						$display("stimulus file names an unknown output %s", name);
						$display("sim failed");
						$fatal(1);
					end
					check_value(name, got, b);
				end
				default: ;  // Comments and blank lines
			endcase
		end
		$fclose(fd);
		$display("sim passed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+logic
logic/sms_pkg.sv
logic/load_if.sv
logic/load_cfg_regs.sv
logic/cart_loader.sv
logic/cheat_assembler.sv
logic/clk_enables.sv
logic/sms_loader_top.sv
dv/sms_loader_chk.sv
dv/sms_loader_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the loader testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wall -Wno-fatal +incdir+logic -f tb.f \
	--top-module sms_loader_tb -o sms_loader_sim > build.log 2>&1 \
	&& ./obj_dir/sms_loader_sim > sim.log 2>&1 \
	|| echo "build or run stopped early"
cat sim.log 2>/dev/null
grep -q "^sim passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== dv/sms_loader_stim.txt ====
# S idx | W addr data | F addr count | E | C cycles | X output value
# All numbers hex; F writes count bytes with data folded from the address
S 00
F 0 258
E
C 2
X romwr_a 258
X stored 258
X cart_mask 3FF
X cart_mask512 7F
X cart_sz512 1
S 02
W 0 3C
E
C 1
X gg 1
X systeme 0
S 04
W 0 A5
E
C 1
X systeme 1
X sysmode A5
S FE
W 0 11
W 1 22
W 2 33
W 3 44
E
C 1
X dsw_f2 11
X dsw_f3 22
X dsw_e0 33
S 01
W 7FFC 13
W 7FFD 70
W 7FFE 01
W 7FFF 4F
X ysj_quirk 0
W 8000 00
C 1
X ysj_quirk 1
E
S 01
C 2
X ysj_quirk 0
W 0 00
E
S FF
F 0 10
E
C 2
X strobes 1
X cheat_flags 03020100
X cheat_addr 07060504
X cheat_compare 0B0A0908
X cheat_replace 0F0E0D0C
